// ==== common/umult_defs.svh ====
// Unsigned multiplier sizing: operand width, Booth step count and pass count.
`ifndef UMULT_DEFS_SVH
`define UMULT_DEFS_SVH

// Operand width of the multiplier.
`define UMULT_WIDTH 32

// Booth steps, equal to the operand width plus two zero bits of extension.
`define UMULT_STEPS (`UMULT_WIDTH + 2)

// ------------------------------------------------------------
// Steps chained in one clock. Must divide UMULT_STEPS.
// Valid choices for 32-bit operands are 1, 2, 17 and 34.
// ------------------------------------------------------------
`define UMULT_STEPS_PER_CYCLE 17

// Clock cycles spent on one multiply.
`define UMULT_PASSES (`UMULT_STEPS / `UMULT_STEPS_PER_CYCLE)

`endif

// ==== common/umult_pkg.sv ====
// Unsigned multiplier types: operands, product, Booth accumulator, state and step operation.
`include "umult_defs.svh"

package umult_pkg;

    // Unsigned multiplicand or multiplier.
    typedef logic [`UMULT_WIDTH-1:0] operand_t;

    // Full unsigned product.
    typedef logic [2*`UMULT_WIDTH-1:0] product_t;

    // Upper accumulator, also used for the extended multiplicand.
    typedef logic [`UMULT_STEPS-1:0] acc_t;

    // Accumulator, then multiplier / low product half, then the extra Booth bit.
    typedef logic [2*`UMULT_STEPS:0] state_t;

    // Operation picked by one Booth step.
    typedef enum logic [1:0] {
        BOOTH_NONE = 2'd0,
        BOOTH_ADD  = 2'd1,
        BOOTH_SUB  = 2'd2
    } booth_op_e;

endpackage

// ==== files.f ====
+incdir+common
common/umult_pkg.sv
umult/booth_step.sv
umult/umult_datapath.sv
umult/umult_ctrl.sv
hw/umult_top.sv
sim/umult_properties.sv
sim/umult_tb.sv

// ==== hw/umult_top.sv ====
// Unsigned multiplier top: connects the controller to the Booth datapath.
`timescale 1ns/1ns

module umult_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  umult_pkg::operand_t in1,
    input  umult_pkg::operand_t in2,
    output logic                busy,
    output logic                done,
    output umult_pkg::product_t product
);

    logic load;
    logic advance;
    logic capture;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------

    umult_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .load    (load),
        .advance (advance),
        .capture (capture),
        .busy    (busy),
        .done    (done)
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------

    umult_datapath u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .advance (advance),
        .capture (capture),
        .in1     (in1),
        .in2     (in2),
        .product (product)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module umult_tb --Mdir "$BUILD_DIR" -o umult_sim \
    -f files.f

"./$BUILD_DIR/umult_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qxF '** PASS **' "$LOG"
then
    echo "run_sim: simulation passed"
    exit 0
fi
echo "run_sim: simulation failed, see $LOG"
exit 1

// ==== sim/umult_properties.sv ====
// Bound checks on the multiplier strobes: done pulse width, busy length and reset values.
`timescale 1ns/1ns
`include "umult_defs.svh"

module umult_properties (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);

    // ------------------------------------------------------------
    // Done strobe
    // ------------------------------------------------------------

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Done is registered from capture, so busy was high one cycle before.
    done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(busy))
        else $error("done rose without a busy cycle before it");

    // ------------------------------------------------------------
    // Busy length
    // ------------------------------------------------------------

    accept_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else $error("accepted start did not raise busy");

    // Busy falls exactly UMULT_PASSES cycles after the accepting edge.
    busy_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> $past(start && !busy, `UMULT_PASSES + 1))
        else $error("busy length differs from the pass count");

    // ------------------------------------------------------------
    // Reset
    // ------------------------------------------------------------

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> (!busy && !done))
        else $error("busy or done high during reset");

endmodule

bind umult_top umult_properties u_props (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

// ==== sim/umult_tb.sv ====
// Testbench for the multi-cycle unsigned Booth multiplier: table of products and strobe timing.
`timescale 1ns/1ns
`include "umult_defs.svh"

module umult_tb;

    localparam int NUM_FIXED   = 8;
    localparam int NUM_RANDOM  = 12;
    localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * (`UMULT_PASSES + 4) + 50;
    localparam logic [31:0] LCG_SEED = 32'd14648;

    // Plain entry, entry with an ignored start while busy, entry chained into the next.
    localparam int MODE_PLAIN   = 0;
    localparam int MODE_INTRUDE = 1;
    localparam int MODE_CHAIN   = 2;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    umult_pkg::operand_t in1;
    umult_pkg::operand_t in2;
    logic                busy;
    logic                done;
    umult_pkg::product_t product;

    umult_pkg::operand_t tbl_a    [NUM_ENTRIES];
    umult_pkg::operand_t tbl_b    [NUM_ENTRIES];
    int                  tbl_mode [NUM_ENTRIES];
    umult_pkg::product_t tbl_exp  [NUM_ENTRIES];

    logic [31:0] lcg_state;
    int          cycle_count   = 0;
    int          checked       = 0;
    int          value_errors  = 0;
    int          timing_errors = 0;

    umult_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .in1     (in1),
        .in2     (in2),
        .busy    (busy),
        .done    (done),
        .product (product)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic record_error(input bit timing, input string msg);
        if (timing)
            timing_errors = timing_errors + 1;
        else
            value_errors = value_errors + 1;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    task automatic print_counts(input int timeouts);
        $display("Results checked: %0d  value errors: %0d  timing errors: %0d  timeouts: %0d",
                 checked, value_errors, timing_errors, timeouts);
    endtask

    // Expected product is the full 64-bit unsigned product of the pair.
    task automatic add_entry(input int idx, input umult_pkg::operand_t a,
                             input umult_pkg::operand_t b, input int mode);
        tbl_a[idx]    = a;
        tbl_b[idx]    = b;
        tbl_mode[idx] = mode;
        tbl_exp[idx]  = umult_pkg::product_t'(a) * umult_pkg::product_t'(b);
    endtask

    task automatic fill_table();
        umult_pkg::operand_t a;
        umult_pkg::operand_t b;
        int                  mode;

        add_entry(0, 32'h0000_0000, 32'hDEAD_BEEF, MODE_PLAIN);
        add_entry(1, 32'h1234_5678, 32'h0000_0000, MODE_PLAIN);
        add_entry(2, 32'h0000_0001, 32'hCAFE_F00D, MODE_INTRUDE);
        add_entry(3, 32'h89AB_CDEF, 32'h0000_0001, MODE_PLAIN);
        add_entry(4, 32'hFFFF_FFFF, 32'hFFFF_FFFF, MODE_CHAIN);
        // Alternating bits give a Booth add or subtract on every step.
        add_entry(5, 32'hAAAA_AAAA, 32'h5555_5555, MODE_CHAIN);
        add_entry(6, 32'h5555_5555, 32'hAAAA_AAAA, MODE_PLAIN);
        add_entry(7, 32'h8000_0000, 32'h8000_0000, MODE_PLAIN);
        lcg_state = LCG_SEED;
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++)
        begin
            a = lcg_next();
            b = lcg_next();
            if (i == 10 || i == 15)
                mode = MODE_CHAIN;
            else if (i == 13)
                mode = MODE_INTRUDE;
            else
                mode = MODE_PLAIN;
            add_entry(i, a, b, mode);
        end
    endtask

    // ------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Run timed out after %0d cycles before the table was finished",
                     cycle_count);
            print_counts(1);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------

    initial
    begin
        int                  edges;
        int                  idle;
        umult_pkg::product_t held;

        rst_n = 1'b0;
        start = 1'b0;
        in1   = '0;
        in2   = '0;
        held  = '0;
        fill_table();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        repeat (2)
        begin
            @(negedge clk);
            assert (!busy && !done && product == '0)
                else record_error(1'b0, $sformatf("after reset busy=%b done=%b product=%h",
                                                  busy, done, product));
        end

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            in1   = tbl_a[i];
            in2   = tbl_b[i];
            start = 1'b1;
            edges = 0;
            do
            begin
                @(negedge clk);
                edges = edges + 1;
                // Changed operands after the start edge must not reach the product.
                in1   = ~tbl_a[i];
                in2   = ~tbl_b[i];
                start = (tbl_mode[i] == MODE_INTRUDE) && (edges == 1);
                if (!done)
                begin
                    assert (busy)
                        else record_error(1'b1, $sformatf("entry %0d: busy low %0d cycles in",
                                                          i, edges));
                    assert (product == held)
                        else record_error(1'b0, $sformatf("entry %0d: product %h, held %h",
                                                          i, product, held));
                end
            end
            while (!done);

            checked = checked + 1;
            assert (edges - 1 == `UMULT_PASSES)
                else record_error(1'b1, $sformatf("entry %0d: done after %0d cycles, expected %0d",
                                                  i, edges - 1, `UMULT_PASSES));
            assert (!busy)
                else record_error(1'b1, $sformatf("entry %0d: busy high with done", i));
            assert (product == tbl_exp[i])
                else record_error(1'b0, $sformatf("entry %0d: %h * %h gave %h, expected %h",
                                                  i, tbl_a[i], tbl_b[i], product, tbl_exp[i]));
            held = tbl_exp[i];

            // Chained entries start the next multiply in the done cycle.
            if (tbl_mode[i] != MODE_CHAIN)
            begin
                idle = (tbl_mode[i] == MODE_INTRUDE) ? `UMULT_PASSES + 1 : 1;
                repeat (idle)
                begin
                    @(negedge clk);
                    assert (!done && !busy)
                        else record_error(1'b1, $sformatf("entry %0d: done=%b busy=%b when idle",
                                                          i, done, busy));
                    assert (product == held)
                        else record_error(1'b0, $sformatf("entry %0d: idle product %h, held %h",
                                                          i, product, held));
                end
            end
        end

        print_counts(0);
        if (value_errors == 0 && timing_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== umult/booth_step.sv ====
// Booth step: decodes two state bits, adds or subtracts the multiplicand, shifts right.
`timescale 1ns/1ns
`include "umult_defs.svh"

module booth_step (
    input  umult_pkg::state_t    state_in,
    input  umult_pkg::acc_t      multiplicand,
    output umult_pkg::state_t    state_out,
    output umult_pkg::booth_op_e op
);

    umult_pkg::acc_t   acc_in;
    umult_pkg::acc_t   acc_next;
    umult_pkg::state_t pre_shift;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------

    // Bit 1 is the current multiplier bit, bit 0 the previous one.
    always_comb
    begin
        case (state_in[1:0])
            2'b01:   op = umult_pkg::BOOTH_ADD;
            2'b10:   op = umult_pkg::BOOTH_SUB;
            default: op = umult_pkg::BOOTH_NONE;
        endcase
    end

    // ------------------------------------------------------------
    // Add or subtract, then shift
    // ------------------------------------------------------------

    assign acc_in = state_in[2*`UMULT_STEPS:`UMULT_STEPS+1];

    always_comb
    begin
        case (op)
            umult_pkg::BOOTH_ADD: acc_next = acc_in + multiplicand;
            umult_pkg::BOOTH_SUB: acc_next = acc_in - multiplicand;
            default:              acc_next = acc_in;
        endcase
    end

    // Low half and Booth bit pass through untouched before the shift.
    assign pre_shift = {acc_next, state_in[`UMULT_STEPS:0]};

    // Arithmetic shift, the accumulator sign bit fills from the top.
    assign state_out = {pre_shift[2*`UMULT_STEPS], pre_shift[2*`UMULT_STEPS:1]};

endmodule

// ==== umult/umult_ctrl.sv ====
// Multiplier controller: accepts start when idle, counts passes, issues capture and done.
`timescale 1ns/1ns
`include "umult_defs.svh"

module umult_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic load,
    output logic advance,
    output logic capture,
    output logic busy,
    output logic done
);

    localparam int CNT_W = (`UMULT_PASSES > 1) ? $clog2(`UMULT_PASSES) : 1;
    localparam logic [CNT_W-1:0] LAST_PASS = CNT_W'(`UMULT_PASSES - 1);

    logic [CNT_W-1:0] pass_cnt;

    // ------------------------------------------------------------
    // Strobes to the datapath
    // ------------------------------------------------------------

    // A start while busy is dropped.
    assign load    = start && !busy;
    assign advance = busy;
    assign capture = busy && (pass_cnt == LAST_PASS);

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------

    // Busy spans exactly UMULT_PASSES cycles.
    // Done follows the capture edge for one cycle, when a new start is allowed.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            pass_cnt <= '0;
        end
        else
        begin
            done <= capture;
            if (load)
            begin
                busy     <= 1'b1;
                pass_cnt <= '0;
            end
            else if (capture)
            begin
                busy     <= 1'b0;
                pass_cnt <= '0;
            end
            else if (busy)
            begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== umult/umult_datapath.sv ====
// Multiplier datapath holding the Booth state, one pass of chained steps and the product.
`timescale 1ns/1ns
`include "umult_defs.svh"

module umult_datapath (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  logic                advance,
    input  logic                capture,
    input  umult_pkg::operand_t in1,
    input  umult_pkg::operand_t in2,
    output umult_pkg::product_t product
);

    localparam int NSTEP = `UMULT_STEPS_PER_CYCLE;

    umult_pkg::state_t state_q;
    umult_pkg::acc_t   mcand_q;

    // Result of this pass after the last chained step.
    umult_pkg::state_t pass_out;

    // ------------------------------------------------------------
    // Step chain
    // ------------------------------------------------------------

    // The first step takes the registered state and each later step the one before it.
    generate
        for (genvar i = 0; i < NSTEP; i++)
        begin : g_step
            umult_pkg::state_t step_in;
            umult_pkg::state_t step_out;

            if (i == 0)
            begin : g_first
                assign step_in = state_q;
            end
            else
            begin : g_next
                assign step_in = g_step[i-1].step_out;
            end

            booth_step u_step (
                .state_in     (step_in),
                .multiplicand (mcand_q),
                .state_out    (step_out),
                .op           ()
            );
        end
    endgenerate

    assign pass_out = g_step[NSTEP-1].step_out;

    // ------------------------------------------------------------
    // State and multiplicand
    // ------------------------------------------------------------

    // Load places in1 in the low half above a zero Booth bit.
    // Both operands are zero-extended so they stay positive in Booth form.
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            state_q <= {umult_pkg::acc_t'(0), umult_pkg::acc_t'(in1), 1'b0};
            mcand_q <= umult_pkg::acc_t'(in2);
        end
        else if (advance)
        begin
            state_q <= pass_out;
        end
    end

    // ------------------------------------------------------------
    // Product
    // ------------------------------------------------------------

    // Written on the edge of the last advance, straight from the chain.
    // Holds until the next capture.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            product <= '0;
        end
        else if (capture)
        begin
            product <= pass_out[2*`UMULT_WIDTH:1];
        end
    end

endmodule
